// File: build.f
design/soc_bus_pkg.sv
design/soc_debug_pkg.sv
design/apb_to_per_bridge.sv
design/soc_debug_regs.sv
design/soc_watchdog.sv
design/soc_reset_ctrl.sv
design/pf_event_rx.sv
design/soc_domain_top.sv
testbench/soc_domain_asserts.sv
testbench/tb_soc_domain.sv

// File: Makefile
TOP := tb_soc_domain
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f build.f

run: compile
	@out=$$(./$(OBJ)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ)

// File: testbench/tb_soc_domain.sv
`timescale 1ns/10ps

module tb_soc_domain
  import soc_bus_pkg::*;
  import soc_debug_pkg::*;
();

  localparam int unsigned CLK_NS = 100;

  // nscratch [23:20], dataaccess [16], datasize [15:12], dataaddr [11:0]
  localparam logic [31:0] HARTINFO_EXP =
    (32'd2 << 20) | (32'd1 << 16) | (32'd2 << 12) | 32'h380;

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_EVENTS,
    OP_HOLD,
    OP_WAIT,
    OP_DMACTIVE
  } op_e;

  // hold, wait and dmactive rows keep the expected level in exp_val[0]
  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_val;
    logic        exp_err;
  } row_t;

  logic        s_soc_clk;
  logic        s_soc_rstn;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        pf_evt_valid;
  logic        pf_evt_ack;
  logic        sys_rstn;
  logic        dmactive;
  row_t        table_q[$];
  logic [31:0] rand_words[4];
  int unsigned n_rows = 0;

  soc_domain_top soc_domain_top_inst (
    .s_soc_clk     (s_soc_clk),
    .s_soc_rstn    (s_soc_rstn),
    .apb_req_i     (apb_req),
    .apb_rsp_o     (apb_rsp),
    .pf_evt_valid_i(pf_evt_valid),
    .pf_evt_ack_o  (pf_evt_ack),
    .sys_rstn_o    (sys_rstn),
    .dmactive_o    (dmactive)
  );

  initial begin
    s_soc_clk = 1'b0;
    forever #(CLK_NS / 2) s_soc_clk = ~s_soc_clk;
  end

  // run limit scales with the table length
  initial begin
    wait (n_rows != 0);
    #(n_rows * 200 * CLK_NS);
    $display("timeout, the stimulus table did not finish in time");
    $display("ERRORS FOUND");
    $fatal(1, "simulation timeout");
  end

  // bound checkers raise a flag when one of their assertions fails
  initial begin
    wait (soc_domain_top_inst.apb_to_per_bridge_inst.bridge_asserts_inst.failed |
          soc_domain_top_inst.pf_event_rx_inst.evt_asserts_inst.failed);
    $display("a bound assertion failed during the run");
    $display("ERRORS FOUND");
    $fatal(1, "bound assertion failure");
  end

  // ************************************************************************
  // helpers
  // ************************************************************************

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [31:0] reg_addr(input dbg_reg_e r);
    return {26'b0, r, 2'b00};
  endfunction

  function automatic void add_row(input op_e op, input logic [31:0] addr,
                                  input logic [31:0] data, input logic [31:0] exp_val,
                                  input logic exp_err);
    row_t row;
    row.op      = op;
    row.addr    = addr;
    row.data    = data;
    row.exp_val = exp_val;
    row.exp_err = exp_err;
    table_q.push_back(row);
  endfunction

  // one APB3 transfer, responses sampled at the falling edge
  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int unsigned cycles;
    @(posedge s_soc_clk);
    apb_req.paddr   <= addr;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.pwdata  <= wdata;
    cycles = 1;
    @(posedge s_soc_clk);
    apb_req.penable <= 1'b1;
    do begin
      @(negedge s_soc_clk);
      cycles++;
      if (cycles > 10) begin
        abort_run("pready never came back for an APB transfer");
      end
    end while (!apb_rsp.pready);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_value("apb transfer cycles", cycles, 32'd3);
    @(posedge s_soc_clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  // four-phase handshake, paced by the acknowledge
  task automatic send_event();
    int unsigned waited;
    @(posedge s_soc_clk);
    pf_evt_valid <= 1'b1;
    waited = 0;
    do begin
      @(negedge s_soc_clk);
      waited++;
      if (waited > 20) begin
        abort_run("pf_evt_ack_o did not rise after the event was raised");
      end
    end while (!pf_evt_ack);
    @(posedge s_soc_clk);
    pf_evt_valid <= 1'b0;
    waited = 0;
    do begin
      @(negedge s_soc_clk);
      waited++;
      if (waited > 20) begin
        abort_run("pf_evt_ack_o did not fall after the event was lowered");
      end
    end while (pf_evt_ack);
  endtask

  task automatic wait_rstn(input logic level);
    int unsigned waited;
    waited = 0;
    do begin
      @(negedge s_soc_clk);
      waited++;
      if (waited > 100) begin
        abort_run("sys_rstn_o never reached the expected level");
      end
    end while (sys_rstn !== level);
  endtask

  task automatic hold_rstn(input logic level, input int unsigned cycles);
    repeat (cycles) begin
      @(negedge s_soc_clk);
      check_value("sys_rstn_o", 32'(sys_rstn), 32'(level));
    end
  endtask

  task automatic check_dmactive(input logic level);
    @(negedge s_soc_clk);
    check_value("dmactive_o", 32'(dmactive), 32'(level));
  endtask

  // ************************************************************************
  // stimulus table
  // ************************************************************************

  function automatic void build_table();
    for (int i = 0; i < 4; i++) begin
      rand_words[i] = $urandom();
    end
    // debug session is off after reset
    add_row(OP_DMACTIVE, 32'd0, 32'd0, 32'd0, 1'b0);
    // data and scratch words, hart info
    for (int i = 0; i < 4; i++) begin
      add_row(OP_WRITE, 32'(i * 4), rand_words[i], 32'd0, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      add_row(OP_READ, 32'(i * 4), 32'd0, rand_words[i], 1'b0);
    end
    add_row(OP_READ, reg_addr(HARTINFO), 32'd0, HARTINFO_EXP, 1'b0);
    // unmapped words and a read-only word
    add_row(OP_READ, 32'h28, 32'd0, 32'd0, 1'b1);
    add_row(OP_READ, 32'h100, 32'd0, 32'd0, 1'b1);
    add_row(OP_WRITE, reg_addr(HARTINFO), 32'hffff_ffff, 32'd0, 1'b0);
    add_row(OP_READ, reg_addr(HARTINFO), 32'd0, HARTINFO_EXP, 1'b0);
    // events
    add_row(OP_EVENTS, 32'd0, 32'd5, 32'd0, 1'b0);
    add_row(OP_READ, reg_addr(EVENT_COUNT), 32'd0, 32'd5, 1'b0);
    add_row(OP_EVENTS, 32'd0, 32'd3, 32'd0, 1'b0);
    add_row(OP_READ, reg_addr(EVENT_COUNT), 32'd0, 32'd8, 1'b0);
    // watchdog expiry, then disable before it fires again
    add_row(OP_WRITE, reg_addr(WDOG_LOAD), 32'd12, 32'd0, 1'b0);
    add_row(OP_WRITE, reg_addr(WDOG_CTRL), 32'd1, 32'd0, 1'b0);
    add_row(OP_WAIT, 32'd0, 32'd0, 32'd0, 1'b0);
    add_row(OP_WAIT, 32'd0, 32'd0, 32'd1, 1'b0);
    add_row(OP_WRITE, reg_addr(WDOG_CTRL), 32'd0, 32'd0, 1'b0);
    add_row(OP_READ, reg_addr(RESET_CAUSE), 32'd0, 32'd1, 1'b0);
    add_row(OP_READ, reg_addr(EVENT_COUNT), 32'd0, 32'd0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      add_row(OP_READ, 32'(i * 4), 32'd0, rand_words[i], 1'b0);
    end
    // debug session pauses the watchdog, ndmreset holds the system reset
    add_row(OP_WRITE, reg_addr(CONTROL), 32'd1, 32'd0, 1'b0);
    add_row(OP_READ, reg_addr(CONTROL), 32'd0, 32'd1, 1'b0);
    add_row(OP_DMACTIVE, 32'd0, 32'd0, 32'd1, 1'b0);
    add_row(OP_WRITE, reg_addr(WDOG_LOAD), 32'd20, 32'd0, 1'b0);
    add_row(OP_WRITE, reg_addr(WDOG_CTRL), 32'd1, 32'd0, 1'b0);
    add_row(OP_HOLD, 32'd0, 32'd40, 32'd1, 1'b0);
    add_row(OP_WRITE, reg_addr(CONTROL), 32'd3, 32'd0, 1'b0);
    add_row(OP_WAIT, 32'd0, 32'd0, 32'd0, 1'b0);
    add_row(OP_HOLD, 32'd0, 32'd10, 32'd0, 1'b0);
    add_row(OP_WRITE, reg_addr(CONTROL), 32'd1, 32'd0, 1'b0);
    add_row(OP_WAIT, 32'd0, 32'd0, 32'd1, 1'b0);
    add_row(OP_READ, reg_addr(RESET_CAUSE), 32'd0, 32'd2, 1'b0);
    add_row(OP_WRITE, reg_addr(WDOG_CTRL), 32'd0, 32'd0, 1'b0);
    add_row(OP_WRITE, reg_addr(CONTROL), 32'd0, 32'd0, 1'b0);
    add_row(OP_READ, reg_addr(CONTROL), 32'd0, 32'd0, 1'b0);
    add_row(OP_DMACTIVE, 32'd0, 32'd0, 32'd0, 1'b0);
  endfunction

  // ************************************************************************
  // main sequence
  // ************************************************************************

  initial begin
    row_t        row;
    logic [31:0] rdata;
    logic        err;

    void'($urandom(59267));
    s_soc_rstn   = 1'b0;
    apb_req      = '0;
    pf_evt_valid = 1'b0;
    build_table();
    n_rows = table_q.size();

    repeat (4) @(posedge s_soc_clk);
    s_soc_rstn <= 1'b1;
    wait_rstn(1'b1);

    foreach (table_q[i]) begin
      row = table_q[i];
      case (row.op)
        OP_WRITE: begin
          apb_transfer(1'b1, row.addr, row.data, rdata, err);
          check_value("apb_rsp_o.pslverr", 32'(err), 32'(row.exp_err));
        end
        OP_READ: begin
          apb_transfer(1'b0, row.addr, 32'd0, rdata, err);
          check_value("apb_rsp_o.prdata", rdata, row.exp_val);
          check_value("apb_rsp_o.pslverr", 32'(err), 32'(row.exp_err));
        end
        OP_EVENTS:   repeat (row.data) send_event();
        OP_HOLD:     hold_rstn(row.exp_val[0], row.data);
        OP_WAIT:     wait_rstn(row.exp_val[0]);
        OP_DMACTIVE: check_dmactive(row.exp_val[0]);
        default:     abort_run("unknown operation in the stimulus table");
      endcase
    end

    // flags raised by the bound checkers
    if (soc_domain_top_inst.apb_to_per_bridge_inst.bridge_asserts_inst.failed |
        soc_domain_top_inst.pf_event_rx_inst.evt_asserts_inst.failed) begin
      $display("ERRORS FOUND");
      $fatal(1, "a bound assertion failed during the run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// File: testbench/soc_domain_asserts.sv
`timescale 1ns/10ps

module soc_domain_asserts
  import soc_bus_pkg::*;
(
  input logic     clk_i,
  input logic     rstn_i,
  input apb_req_t apb_req_i,
  input apb_rsp_t apb_rsp_i,
  input logic     evt_req_i,
  input logic     evt_ack_i
);

  logic pulse_err   = 1'b0;
  logic latency_err = 1'b0;
  logic ack_err     = 1'b0;
  logic failed;

  assign failed = pulse_err | latency_err | ack_err;

  // ************************************************************************
  // APB completion
  // ************************************************************************

  // pready is a single-cycle strobe
  ready_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    apb_rsp_i.pready |=> !apb_rsp_i.pready
  ) else begin
    $error("pready stayed high for more than one cycle");
    pulse_err = 1'b1;
  end

  // setup, access with pready low, access with pready high
  ready_latency: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    $rose(apb_req_i.psel) |-> ##2 apb_rsp_i.pready
  ) else begin
    $error("pready did not follow two cycles after psel");
    latency_err = 1'b1;
  end

  // ************************************************************************
  // event handshake
  // ************************************************************************

  // ack rises only on a request seen high by the synchronizer
  ack_rise_on_request: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    $rose(evt_ack_i) |-> $past(evt_req_i)
  ) else begin
    $error("ack rose while the synchronized request was low");
    ack_err = 1'b1;
  end

  // ack stays up until the request is seen low again
  ack_fall_on_release: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    $fell(evt_ack_i) |-> !$past(evt_req_i)
  ) else begin
    $error("ack fell while the synchronized request was still high");
    ack_err = 1'b1;
  end

endmodule

bind apb_to_per_bridge soc_domain_asserts bridge_asserts_inst (
  .clk_i    (s_soc_clk),
  .rstn_i   (sys_rstn_i),
  .apb_req_i(apb_req_i),
  .apb_rsp_i(apb_rsp_o),
  .evt_req_i(1'b0),
  .evt_ack_i(1'b0)
);

bind pf_event_rx soc_domain_asserts evt_asserts_inst (
  .clk_i    (s_soc_clk),
  .rstn_i   (sys_rstn_i),
  .apb_req_i('0),
  .apb_rsp_i('0),
  .evt_req_i(valid_sync),
  .evt_ack_i(ack_o)
);

// File: design/soc_domain_top.sv
`timescale 1ns/10ps

module soc_domain_top
  import soc_bus_pkg::*;
  import soc_debug_pkg::*;
#(
  parameter int unsigned RST_STRETCH = 4,
  parameter int unsigned WDOG_WIDTH  = 16
) (
  input  logic     s_soc_clk,
  input  logic     s_soc_rstn,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  logic     pf_evt_valid_i,
  output logic     pf_evt_ack_o,
  output logic     sys_rstn_o,
  output logic     dmactive_o
);

  // ************************************************************************
  // internal wiring
  // ************************************************************************

  per_req_t              s_per_req;
  per_rsp_t              s_per_rsp;
  logic                  s_ndmreset;
  logic                  s_wdog_en;
  logic                  s_wdog_kick;
  logic [WDOG_WIDTH-1:0] s_wdog_load;
  logic                  s_wd_expired;
  logic [31:0]           s_event_count;
  reset_cause_t          s_reset_cause;

  // ************************************************************************
  // register path
  // ************************************************************************

  apb_to_per_bridge apb_to_per_bridge_inst (
    .s_soc_clk (s_soc_clk),
    .sys_rstn_i(sys_rstn_o),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .per_req_o (s_per_req),
    .per_rsp_i (s_per_rsp)
  );

  // register block runs on the global reset so it survives a system reset
  soc_debug_regs #(
    .WDOG_WIDTH(WDOG_WIDTH)
  ) soc_debug_regs_inst (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .per_req_i    (s_per_req),
    .per_rsp_o    (s_per_rsp),
    .event_count_i(s_event_count),
    .reset_cause_i(s_reset_cause),
    .dmactive_o   (dmactive_o),
    .ndmreset_o   (s_ndmreset),
    .wdog_en_o    (s_wdog_en),
    .wdog_kick_o  (s_wdog_kick),
    .wdog_load_o  (s_wdog_load)
  );

  // ************************************************************************
  // watchdog and system reset
  // ************************************************************************

  // watchdog holds while a debug session is active
  soc_watchdog #(
    .WDOG_WIDTH(WDOG_WIDTH)
  ) soc_watchdog_inst (
    .s_soc_clk (s_soc_clk),
    .sys_rstn_i(sys_rstn_o),
    .en_i      (s_wdog_en),
    .kick_i    (s_wdog_kick),
    .pause_i   (dmactive_o),
    .load_i    (s_wdog_load),
    .expired_o (s_wd_expired)
  );

  soc_reset_ctrl #(
    .RST_STRETCH(RST_STRETCH)
  ) soc_reset_ctrl_inst (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .wd_expired_i (s_wd_expired),
    .ndmreset_i   (s_ndmreset),
    .sys_rstn_o   (sys_rstn_o),
    .reset_cause_o(s_reset_cause)
  );

  // event receiver from the cluster side
  pf_event_rx pf_event_rx_inst (
    .s_soc_clk    (s_soc_clk),
    .sys_rstn_i   (sys_rstn_o),
    .valid_i      (pf_evt_valid_i),
    .ack_o        (pf_evt_ack_o),
    .event_count_o(s_event_count)
  );

endmodule

// File: design/pf_event_rx.sv
`timescale 1ns/10ps

module pf_event_rx
  import soc_debug_pkg::*;
(
  input  logic        s_soc_clk,
  input  logic        sys_rstn_i,
  input  logic        valid_i,
  output logic        ack_o,
  output logic [31:0] event_count_o
);

  logic [1:0]  sync_q;
  logic        valid_sync;
  evt_state_e  state_q;
  logic [31:0] count_q;

  // two-flop synchronizer on the incoming request
  always_ff @(posedge s_soc_clk or negedge sys_rstn_i) begin
    if (!sys_rstn_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], valid_i};
    end
  end

  assign valid_sync = sync_q[1];

  // four-phase handshake
  // rising request counts one event, ack follows the state
  always_ff @(posedge s_soc_clk or negedge sys_rstn_i) begin
    if (!sys_rstn_i) begin
      state_q <= WAIT_HIGH;
      count_q <= '0;
    end else begin
      if (state_q == WAIT_HIGH) begin
        if (valid_sync) begin
          state_q <= WAIT_LOW;
          count_q <= count_q + 32'd1;
        end
      end else begin
        if (!valid_sync) begin
          state_q <= WAIT_HIGH;
        end
      end
    end
  end

  assign ack_o         = (state_q == WAIT_LOW);
  assign event_count_o = count_q;

endmodule

// File: design/soc_reset_ctrl.sv
`timescale 1ns/10ps

module soc_reset_ctrl
  import soc_debug_pkg::*;
#(
  parameter int unsigned RST_STRETCH = 4
) (
  input  logic         s_soc_clk,
  input  logic         s_soc_rstn,
  input  logic         wd_expired_i,
  input  logic         ndmreset_i,
  output logic         sys_rstn_o,
  output reset_cause_t reset_cause_o
);

  localparam int unsigned CNT_WIDTH = $clog2(RST_STRETCH + 1);

  logic [CNT_WIDTH-1:0] stretch_q;
  logic                 rstn_q;
  logic                 trigger;
  reset_cause_t         cause_q;

  assign trigger = wd_expired_i | ndmreset_i;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      stretch_q <= CNT_WIDTH'(RST_STRETCH);
      rstn_q    <= 1'b0;
      cause_q   <= '0;
    end else begin
      if (trigger) begin
        stretch_q <= CNT_WIDTH'(RST_STRETCH);
        rstn_q    <= 1'b0;
        // only the source that opens a reset is recorded
        if (rstn_q) begin
          cause_q.watchdog <= wd_expired_i;
          cause_q.ndmreset <= ~wd_expired_i;
        end
      end else if (stretch_q != '0) begin
        stretch_q <= stretch_q - CNT_WIDTH'(1);
        rstn_q    <= (stretch_q == CNT_WIDTH'(1));
      end
    end
  end

  assign sys_rstn_o    = rstn_q;
  assign reset_cause_o = cause_q;

endmodule

// File: design/soc_watchdog.sv
`timescale 1ns/10ps

module soc_watchdog #(
  parameter int unsigned WDOG_WIDTH = 16
) (
  input  logic                  s_soc_clk,
  input  logic                  sys_rstn_i,
  input  logic                  en_i,
  input  logic                  kick_i,
  input  logic                  pause_i,
  input  logic [WDOG_WIDTH-1:0] load_i,
  output logic                  expired_o
);

  logic [WDOG_WIDTH-1:0] count_q;
  logic                  en_q;
  logic                  expired_q;
  logic                  reload;
  logic                  running;

  // reload on kick or on enable going high
  assign reload  = kick_i | (en_i & ~en_q);
  assign running = en_i & ~pause_i & (count_q != '0);

  // after a system reset en_q is low again, so a still enabled
  // watchdog reloads and starts over
  always_ff @(posedge s_soc_clk or negedge sys_rstn_i) begin
    if (!sys_rstn_i) begin
      count_q   <= '0;
      en_q      <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      en_q      <= en_i;
      expired_q <= 1'b0;
      if (reload) begin
        count_q <= load_i;
      end else if (running) begin
        count_q   <= count_q - WDOG_WIDTH'(1);
        // pulse lines up with the count at zero
        expired_q <= (count_q == WDOG_WIDTH'(1));
      end
    end
  end

  assign expired_o = expired_q;

endmodule

// File: design/soc_debug_regs.sv
`timescale 1ns/10ps

module soc_debug_regs
  import soc_bus_pkg::*;
  import soc_debug_pkg::*;
#(
  parameter int unsigned WDOG_WIDTH = 16
) (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  per_req_t              per_req_i,
  output per_rsp_t              per_rsp_o,
  input  logic [31:0]           event_count_i,
  input  reset_cause_t          reset_cause_i,
  output logic                  dmactive_o,
  output logic                  ndmreset_o,
  output logic                  wdog_en_o,
  output logic                  wdog_kick_o,
  output logic [WDOG_WIDTH-1:0] wdog_load_o
);

  // data0, data1, scratch0, scratch1
  logic [DATA_WIDTH-1:0] word_q [4];

  logic                  dmactive_q;
  logic                  ndmreset_q;
  logic                  wdog_en_q;
  logic                  wdog_kick_q;
  logic [WDOG_WIDTH-1:0] wdog_load_q;

  dbg_reg_e              reg_sel;
  logic                  in_range;
  logic                  mapped;
  logic                  hit;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] cur_word;
  logic [DATA_WIDTH-1:0] new_word;

  logic                  r_valid_q;
  logic                  r_err_q;
  logic [DATA_WIDTH-1:0] r_rdata_q;

  function automatic logic [DATA_WIDTH-1:0] be_merge(
    input logic [DATA_WIDTH-1:0] old_val,
    input logic [DATA_WIDTH-1:0] new_val,
    input logic [BE_WIDTH-1:0]   be
  );
    logic [DATA_WIDTH-1:0] res;
    res = old_val;
    for (int i = 0; i < BE_WIDTH; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ************************************************************************
  // decode
  // ************************************************************************

  assign reg_sel  = dbg_reg_e'(per_req_i.addr[5:2]);
  assign in_range = (per_req_i.addr[ADDR_WIDTH-1:6] == '0);

  always_comb begin
    mapped   = 1'b1;
    cur_word = '0;
    case (reg_sel)
      DATA0, DATA1, SCRATCH0, SCRATCH1: cur_word = word_q[per_req_i.addr[3:2]];
      CONTROL:     cur_word = {{(DATA_WIDTH-2){1'b0}}, ndmreset_q, dmactive_q};
      HARTINFO:    cur_word = HARTINFO_VALUE;
      WDOG_LOAD:   cur_word = DATA_WIDTH'(wdog_load_q);
      WDOG_CTRL:   cur_word = DATA_WIDTH'(wdog_en_q);
      EVENT_COUNT: cur_word = event_count_i;
      RESET_CAUSE: cur_word = {{(DATA_WIDTH-$bits(reset_cause_t)){1'b0}}, reset_cause_i};
      default:     mapped = 1'b0;
    endcase
  end

  assign hit      = in_range & mapped;
  assign wr_en    = per_req_i.req & per_req_i.we & hit;
  assign new_word = be_merge(cur_word, per_req_i.wdata, per_req_i.be);

  // ************************************************************************
  // register write
  // ************************************************************************

  // word index 0..3 sits in the data/scratch file
  always_ff @(posedge s_soc_clk) begin
    if (wr_en && per_req_i.addr[5:4] == 2'b00) begin
      word_q[per_req_i.addr[3:2]] <= new_word;
    end
  end

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      dmactive_q  <= 1'b0;
      ndmreset_q  <= 1'b0;
      wdog_en_q   <= 1'b0;
      wdog_kick_q <= 1'b0;
      wdog_load_q <= '0;
    end else begin
      wdog_kick_q <= 1'b0;
      if (wr_en) begin
        case (reg_sel)
          CONTROL: begin
            dmactive_q <= new_word[0];
            ndmreset_q <= new_word[1];
          end
          WDOG_LOAD: wdog_load_q <= new_word[WDOG_WIDTH-1:0];
          // bit 1 is a self-clearing kick
          WDOG_CTRL: begin
            wdog_en_q   <= new_word[0];
            wdog_kick_q <= new_word[1];
          end
          default: ;
        endcase
      end
    end
  end

  // ************************************************************************
  // response, one cycle after the request
  // ************************************************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      r_valid_q <= 1'b0;
      r_err_q   <= 1'b0;
    end else begin
      r_valid_q <= per_req_i.req;
      r_err_q   <= per_req_i.req & ~hit;
    end
  end

  always_ff @(posedge s_soc_clk) begin
    if (per_req_i.req) begin
      r_rdata_q <= hit ? cur_word : '0;
    end
  end

  assign per_rsp_o.r_valid = r_valid_q;
  assign per_rsp_o.r_rdata = r_rdata_q;
  assign per_rsp_o.r_err   = r_err_q;

  assign dmactive_o  = dmactive_q;
  assign ndmreset_o  = ndmreset_q;
  assign wdog_en_o   = wdog_en_q;
  assign wdog_kick_o = wdog_kick_q;
  assign wdog_load_o = wdog_load_q;

endmodule

// File: design/apb_to_per_bridge.sv
`timescale 1ns/10ps

module apb_to_per_bridge
  import soc_bus_pkg::*;
  import soc_debug_pkg::*;
(
  input  logic     s_soc_clk,
  input  logic     sys_rstn_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output per_req_t per_req_o,
  input  per_rsp_t per_rsp_i
);

  bridge_state_e state_q;
  bridge_state_e state_d;
  logic          access;
  logic          issue;
  logic          ready;

  // APB access phase
  assign access = apb_req_i.psel & apb_req_i.penable;

  // one request per access phase
  // a response still in flight blocks a second one, also while held in reset
  assign issue = access & (state_q == IDLE) & ~per_rsp_i.r_valid;

  // completion one cycle after the request
  assign ready = access & per_rsp_i.r_valid & (state_q != DONE);

  always_comb begin
    per_req_o.req   = issue;
    per_req_o.we    = apb_req_i.pwrite;
    per_req_o.addr  = apb_req_i.paddr;
    per_req_o.be    = '1;
    per_req_o.wdata = apb_req_i.pwdata;
  end

  always_comb begin
    apb_rsp_o.prdata  = per_rsp_i.r_rdata;
    apb_rsp_o.pready  = ready;
    apb_rsp_o.pslverr = ready & per_rsp_i.r_err;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (issue) begin
          state_d = WAIT_VALID;
        end
      end
      WAIT_VALID: begin
        if (per_rsp_i.r_valid) begin
          state_d = DONE;
        end
      end
      // master drops penable after pready
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge s_soc_clk or negedge sys_rstn_i) begin
    if (!sys_rstn_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: design/soc_debug_pkg.sv
package soc_debug_pkg;

  // word index of the debug register map (byte offset / 4)
  typedef enum logic [3:0] {
    DATA0       = 4'h0,
    DATA1       = 4'h1,
    SCRATCH0    = 4'h2,
    SCRATCH1    = 4'h3,
    CONTROL     = 4'h4,
    HARTINFO    = 4'h5,
    WDOG_LOAD   = 4'h6,
    WDOG_CTRL   = 4'h7,
    EVENT_COUNT = 4'h8,
    RESET_CAUSE = 4'h9
  } dbg_reg_e;

  // hartinfo layout
  //   [23:20] nscratch, [16] dataaccess, [15:12] datasize, [11:0] dataaddr
  localparam logic [31:0] HARTINFO_VALUE = {
    8'h00,
    4'd2,
    3'b000,
    1'b1,
    4'd2,
    12'h380
  };

  // one-hot, bit 0 watchdog, bit 1 ndmreset
  typedef struct packed {
    logic ndmreset;
    logic watchdog;
  } reset_cause_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_VALID,
    DONE
  } bridge_state_e;

  typedef enum logic {
    WAIT_HIGH,
    WAIT_LOW
  } evt_state_e;

endpackage

// File: design/soc_bus_pkg.sv
package soc_bus_pkg;

  // register bus geometry
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // APB master strobes
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // peripheral request, grant is implicit
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [BE_WIDTH-1:0]   be;
    logic [DATA_WIDTH-1:0] wdata;
  } per_req_t;

  typedef struct packed {
    logic                  r_valid;
    logic [DATA_WIDTH-1:0] r_rdata;
    logic                  r_err;
  } per_rsp_t;

endpackage
